// ==== sources.f ====
+incdir+design
design/ifu_pkg.sv
design/icache_if.sv
design/icache_way.sv
design/way_select.sv
design/fetch_ctrl.sv
design/ifu_top.sv
testbench/tb_mem_model.sv
testbench/tb_ifu.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_ifu
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_ifu.sv ====
`default_nettype none
`include "ifu_macros.svh"

module tb_ifu;

  localparam logic [31:0] BASE = `IFU_PC_INIT;

  logic clk, rst, inst_ready_i, redirect_valid_i;
  logic [31:0] redirect_pc_i, mem_araddr_o, mem_rdata_i, inst_o, inst_pc_o;
  logic mem_arvalid_o, mem_arready_i, mem_rvalid_i, inst_valid_o;
  logic [31:0] read_count;

  logic [31:0] exp_pc;
  logic waiting; // set while fetch must wait for a redirect.
  logic line_cached;
  logic m_valid [`IFU_SETS][`IFU_WAYS];
  logic [`IFU_TAG_W-1:0] m_tag [`IFU_SETS][`IFU_WAYS];
  int m_victim [`IFU_SETS];
  int errors, tests, failed_tests, stall_cycles;

  ifu_top DUT (.*);

  tb_mem_model u_mem (
    .clk (clk), .rst (rst), .araddr_i (mem_araddr_o), .arvalid_i (mem_arvalid_o),
    .arready_o (mem_arready_i), .rdata_o (mem_rdata_i), .rvalid_o (mem_rvalid_i),
    .read_count_o (read_count)
  );

  function automatic void mismatch_error(input string name, input logic [31:0] got,
                                         input logic [31:0] expected);
    errors++;
    $display("Fail %0s: got %h expected %h", name, got, expected);
  endfunction

  function automatic void plain_error(input string msg);
    errors++;
    $display("%0s", msg);
  endfunction

  function automatic logic is_transfer(logic [31:0] w);
    return w[6:0] == ifu_pkg::OP_JAL || w[6:0] == ifu_pkg::OP_JALR ||
           w[6:0] == ifu_pkg::OP_BRANCH || w[6:0] == ifu_pkg::OP_SYSTEM;
  endfunction

  function automatic logic model_hit(logic [31:0] a);
    logic hit;
    int set;
    hit = 1'b0;
    set = int'(a[`IFU_OFFSET_BITS+2 +: `IFU_SET_BITS]);
    for (int w = 0; w < `IFU_WAYS; w++)
    begin
      if (m_valid[set][w] && m_tag[set][w] == a[31 -: `IFU_TAG_W])
      begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // the model state before the edge decides whether a request may happen.
  always_comb line_cached = model_hit(mem_araddr_o);

  // expected pc and a round-robin model of the tags.
  always @(posedge clk)
  begin
    int set;
    set = int'(mem_araddr_o[`IFU_OFFSET_BITS+2 +: `IFU_SET_BITS]);
    if (rst)
    begin
      exp_pc       <= BASE;
      waiting      <= 1'b0;
      stall_cycles <= 0;
      for (int s = 0; s < `IFU_SETS; s++)
      begin
        m_victim[s] <= 0;
        for (int w = 0; w < `IFU_WAYS; w++) m_valid[s][w] <= 1'b0;
      end
    end
    else
    begin
      if (inst_valid_o && !inst_ready_i) stall_cycles <= stall_cycles + 1;
      if (inst_valid_o && inst_ready_i)
      begin
        if (is_transfer(inst_o)) waiting <= 1'b1;
        else exp_pc <= exp_pc + 4;
        if (inst_o == ifu_pkg::INST_FENCE_I)
        begin
          for (int s = 0; s < `IFU_SETS; s++)
            for (int w = 0; w < `IFU_WAYS; w++) m_valid[s][w] <= 1'b0;
        end
      end
      if (redirect_valid_i && waiting)
      begin
        waiting <= 1'b0;
        exp_pc  <= redirect_pc_i;
      end
      if (mem_arvalid_o && mem_arready_i)
      begin
        m_valid[set][m_victim[set]] <= 1'b1;
        m_tag[set][m_victim[set]]   <= mem_araddr_o[31 -: `IFU_TAG_W];
        m_victim[set] <= (m_victim[set] + 1) % `IFU_WAYS;
      end
    end
  end

  a_word: assert property (@(posedge clk) disable iff (rst)
    inst_valid_o && inst_ready_i |-> inst_o == u_mem.prog[inst_pc_o[9:2]])
    else mismatch_error("inst_o", $sampled(inst_o), u_mem.prog[$sampled(inst_pc_o[9:2])]);
  a_pc: assert property (@(posedge clk) disable iff (rst)
    inst_valid_o && inst_ready_i |-> inst_pc_o == exp_pc)
    else mismatch_error("inst_pc_o", $sampled(inst_pc_o), $sampled(exp_pc));
  a_quiet: assert property (@(posedge clk) disable iff (rst) waiting |-> !inst_valid_o)
    else plain_error("instruction presented before the redirect");
  a_miss_line: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_o && mem_arready_i |-> mem_araddr_o == {exp_pc[31:3], 3'b000})
    else mismatch_error("mem_araddr_o", $sampled(mem_araddr_o),
                        {$sampled(exp_pc[31:3]), 3'b000});
  a_miss_only: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_o && mem_arready_i |-> !line_cached)
    else plain_error("read request for a line that should hit");
  a_hold: assert property (@(posedge clk) disable iff (rst) inst_valid_o && !inst_ready_i
    |=> inst_valid_o && $stable(inst_o) && $stable(inst_pc_o))
    else plain_error("decode output changed under back-pressure");
  a_reset: assert property (@(posedge clk) rst && $past(rst) |-> !mem_arvalid_o && !inst_valid_o)
    else plain_error("activity on the outputs during reset");

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!waiting && cycles < 500)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!waiting)
    begin
      plain_error("timed out waiting for a control-transfer instruction");
    end
  endtask

  task automatic jump_to(input logic [31:0] target);
    wait_for_halt();
    @(negedge clk);
    redirect_valid_i = 1'b1;
    redirect_pc_i    = target;
    @(negedge clk);
    redirect_valid_i = 1'b0;
    wait_for_halt();
  endtask

  task automatic check_requests(input logic [31:0] start, input logic [31:0] expected);
    assert (read_count - start == expected)
    else mismatch_error("read_count", read_count - start, expected);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors != errors_before) failed_tests++;
    $display("test %0s: %0s", name, (errors == errors_before) ? "ok" : "errors");
  endtask

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    inst_ready_i = 1'b0;
    forever
    begin
      @(negedge clk);
      inst_ready_i = ($urandom_range(3) != 0); // random decode back-pressure.
    end
  end

  initial
  begin
    logic [31:0] addr;
    logic [31:0] start;
    int e;
    void'($urandom(96));
    rst = 1'b1;
    redirect_valid_i = 1'b0;
    redirect_pc_i = '0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    for (int i = 0; i < 256; i++)
    begin
      addr = BASE + 32'(i * 4);
      u_mem.prog[i] = {addr[26:2], ifu_pkg::OP_IMM};
    end
    u_mem.prog[4]  = {25'd0, ifu_pkg::OP_JAL}; // ends the run from 0x00.
    u_mem.prog[9]  = {25'd0, ifu_pkg::OP_JAL};
    u_mem.prog[17] = {25'd0, ifu_pkg::OP_JAL};
    u_mem.prog[32] = ifu_pkg::INST_FENCE_I;
    u_mem.prog[34] = {25'd0, ifu_pkg::OP_JAL};
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    e = errors;
    wait_for_halt();
    check_requests(0, 3);
    report_test("sequential fetch", e);

    e = errors;
    start = read_count;
    jump_to(BASE + 32'h08);
    check_requests(start, 0);
    report_test("redirect into cached line", e);

    // 0x00, 0x20 and 0x40 all map to set 0.
    e = errors;
    start = read_count;
    jump_to(BASE + 32'h20);
    jump_to(BASE + 32'h40);
    check_requests(start, 2);
    start = read_count;
    jump_to(BASE + 32'h20);
    check_requests(start, 0);
    jump_to(BASE + 32'h00);
    check_requests(start, 1);
    report_test("round-robin eviction", e);

    e = errors;
    start = read_count;
    jump_to(BASE + 32'h80);
    check_requests(start, 3);
    start = read_count;
    jump_to(BASE + 32'h08);
    check_requests(start, 2);
    report_test("fence.i flush", e);

    e = errors;
    assert (stall_cycles > 0)
    else plain_error("decode back-pressure was never exercised");
    report_test("back-pressure hold", e);

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial
  begin
    repeat (20000) @(posedge clk);
    $display("simulation ran out of cycles");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_mem_model.sv ====
`default_nettype none
`include "ifu_macros.svh"

module tb_mem_model (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic [`IFU_ADDR_W-1:0] araddr_i,
  input  wire logic                   arvalid_i,
  output logic                        arready_o,
  output logic [`IFU_ADDR_W-1:0]      rdata_o,
  output logic                        rvalid_o,
  output logic [31:0]                 read_count_o
);

  logic [`IFU_ADDR_W-1:0] prog [256]; // filled by the testbench top.
  logic                   busy;
  logic [`IFU_ADDR_W-1:0] base;
  int                     beat;

  // handshakes are seen at the rising edge.
  always @(posedge clk)
  begin
    if (rst)
    begin
      busy         <= 1'b0;
      base         <= '0;
      beat         <= 0;
      read_count_o <= '0;
    end
    else if (!busy && arvalid_i && arready_o)
    begin
      busy         <= 1'b1;
      base         <= araddr_i;
      beat         <= 0;
      read_count_o <= read_count_o + 1;
    end
    else if (busy && rvalid_o)
    begin
      if (beat == `IFU_LINE_WORDS - 1)
      begin
        busy <= 1'b0;
      end
      beat <= beat + 1;
    end
  end

  initial
  begin
    logic [`IFU_ADDR_W-1:0] word_addr;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    forever
    begin
      @(negedge clk);
      word_addr = base + 32'(beat * 4);
      arready_o = !rst && !busy && ($urandom_range(3) != 0); // random address stalls.
      rvalid_o  = !rst && busy && ($urandom_range(2) != 0);
      rdata_o   = prog[word_addr[9:2]];
    end
  end

endmodule

`default_nettype wire

// ==== design/ifu_top.sv ====
`default_nettype none
`include "ifu_macros.svh"

module ifu_top (
  input  wire logic                    clk,
  input  wire logic                    rst,

  output logic [`IFU_ADDR_W-1:0]       mem_araddr_o,
  output logic                         mem_arvalid_o,
  input  wire logic                    mem_arready_i,
  input  wire logic [`IFU_ADDR_W-1:0]  mem_rdata_i,
  input  wire logic                    mem_rvalid_i,

  output logic [`IFU_ADDR_W-1:0]       inst_o,
  output logic [`IFU_ADDR_W-1:0]       inst_pc_o,
  output logic                         inst_valid_o,
  input  wire logic                    inst_ready_i,

  input  wire logic                    redirect_valid_i,
  input  wire logic [`IFU_ADDR_W-1:0]  redirect_pc_i
);

  icache_if lookup_bus ();

  logic [`IFU_WAYS-1:0]     way_hit;
  logic [`IFU_ADDR_W-1:0]   way_data [`IFU_WAYS];
  logic                     lookup_hit;
  logic [`IFU_ADDR_W-1:0]   lookup_inst;
  logic [`IFU_WAY_BITS-1:0] victim_way;
  logic                     refill_done;

  fetch_ctrl u_fetch_ctrl (
    .clk              (clk),
    .rst              (rst),
    .lookup           (lookup_bus),
    .lookup_hit_i     (lookup_hit),
    .lookup_inst_i    (lookup_inst),
    .victim_way_i     (victim_way),
    .refill_done_o    (refill_done),
    .mem_araddr_o     (mem_araddr_o),
    .mem_arvalid_o    (mem_arvalid_o),
    .mem_arready_i    (mem_arready_i),
    .mem_rdata_i      (mem_rdata_i),
    .mem_rvalid_i     (mem_rvalid_i),
    .inst_o           (inst_o),
    .inst_pc_o        (inst_pc_o),
    .inst_valid_o     (inst_valid_o),
    .inst_ready_i     (inst_ready_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i)
  );

  for (genvar w = 0; w < `IFU_WAYS; w++)
  begin : g_way
    icache_way #(
      .WAY_ID (w)
    ) u_way (
      .clk    (clk),
      .rst    (rst),
      .lookup (lookup_bus),
      .hit_o  (way_hit[w]),
      .data_o (way_data[w])
    );
  end

  way_select u_way_select (
    .clk           (clk),
    .rst           (rst),
    .way_hit_i     (way_hit),
    .way_data_i    (way_data),
    .set_index_i   (lookup_bus.index),
    .refill_done_i (refill_done),
    .lookup_hit_o  (lookup_hit),
    .lookup_inst_o (lookup_inst),
    .victim_way_o  (victim_way)
  );

endmodule

`default_nettype wire

// ==== design/fetch_ctrl.sv ====
`default_nettype none
`include "ifu_macros.svh"

module fetch_ctrl (
  input  wire logic                      clk,
  input  wire logic                      rst,

  icache_if.ctrl                         lookup,

  input  wire logic                      lookup_hit_i,
  input  wire logic [`IFU_ADDR_W-1:0]    lookup_inst_i,
  input  wire logic [`IFU_WAY_BITS-1:0]  victim_way_i,
  output logic                           refill_done_o,

  output logic [`IFU_ADDR_W-1:0]         mem_araddr_o,
  output logic                           mem_arvalid_o,
  input  wire logic                      mem_arready_i,
  input  wire logic [`IFU_ADDR_W-1:0]    mem_rdata_i,
  input  wire logic                      mem_rvalid_i,

  output logic [`IFU_ADDR_W-1:0]         inst_o,
  output logic [`IFU_ADDR_W-1:0]         inst_pc_o,
  output logic                           inst_valid_o,
  input  wire logic                      inst_ready_i,

  input  wire logic                      redirect_valid_i,
  input  wire logic [`IFU_ADDR_W-1:0]    redirect_pc_i
);

  localparam logic [`IFU_OFFSET_BITS-1:0] LAST_OFFSET =
    `IFU_OFFSET_BITS'(`IFU_LINE_WORDS - 1);

  ifu_pkg::fetch_state_e        state_q;
  ifu_pkg::fetch_state_e        state_d;
  logic [`IFU_ADDR_W-1:0]       pc_q;
  logic [`IFU_ADDR_W-1:0]       pc_d;
  logic [`IFU_WAY_BITS-1:0]     refill_way_q;
  logic [`IFU_OFFSET_BITS-1:0]  beat_q;

  ifu_pkg::opcode_e             opcode;
  logic                         is_ctrl;
  logic                         is_fence_i;
  logic                         accept;
  logic                         beat_we;
  logic                         last_beat;

  // the registered pc drives the lookup directly.
  assign lookup.index  = pc_q[`IFU_OFFSET_BITS+2 +: `IFU_SET_BITS];
  assign lookup.tag    = pc_q[`IFU_ADDR_W-1 -: `IFU_TAG_W];
  assign lookup.offset = pc_q[2 +: `IFU_OFFSET_BITS];

  assign inst_o       = lookup_inst_i;
  assign inst_pc_o    = pc_q;
  assign inst_valid_o = (state_q == ifu_pkg::ST_LOOKUP) && lookup_hit_i;
  assign accept       = inst_valid_o && inst_ready_i;

  assign opcode     = ifu_pkg::opcode_e'(lookup_inst_i[6:0]);
  assign is_fence_i = (lookup_inst_i == ifu_pkg::INST_FENCE_I);

  always_comb
  begin
    case (opcode)
      ifu_pkg::OP_JAL,
      ifu_pkg::OP_JALR,
      ifu_pkg::OP_BRANCH,
      ifu_pkg::OP_SYSTEM: is_ctrl = 1'b1;
      default:            is_ctrl = 1'b0;
    endcase
  end

  // pc does not move during a miss, so the line address stays stable.
  assign mem_araddr_o  = {pc_q[`IFU_ADDR_W-1:`IFU_OFFSET_BITS+2],
                          {(`IFU_OFFSET_BITS+2){1'b0}}};
  assign mem_arvalid_o = (state_q == ifu_pkg::ST_ADDR);

  assign beat_we   = (state_q == ifu_pkg::ST_BEAT) && mem_rvalid_i;
  assign last_beat = beat_we && (beat_q == LAST_OFFSET);

  assign lookup.refill_we     = beat_we;
  assign lookup.refill_way    = refill_way_q;
  assign lookup.refill_offset = beat_q;
  assign lookup.refill_data   = mem_rdata_i;
  assign lookup.flush         = accept && is_fence_i;

  assign refill_done_o = last_beat; // moves the victim pointer of this set.

  always_comb
  begin
    state_d = state_q;
    pc_d    = pc_q;
    case (state_q)
      ifu_pkg::ST_LOOKUP:
      begin
        if (!lookup_hit_i)
        begin
          state_d = ifu_pkg::ST_ADDR;
        end
        else if (inst_ready_i)
        begin
          if (is_ctrl)
          begin
            state_d = ifu_pkg::ST_WAIT_REDIRECT; // execute supplies the next pc.
          end
          else
          begin
            pc_d = pc_q + `IFU_ADDR_W'(4);
          end
        end
      end
      ifu_pkg::ST_ADDR:
      begin
        if (mem_arready_i)
        begin
          state_d = ifu_pkg::ST_BEAT;
        end
      end
      ifu_pkg::ST_BEAT:
      begin
        if (last_beat)
        begin
          state_d = ifu_pkg::ST_LOOKUP;
        end
      end
      default:
      begin
        if (redirect_valid_i)
        begin
          pc_d    = redirect_pc_i;
          state_d = ifu_pkg::ST_LOOKUP;
        end
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= ifu_pkg::ST_LOOKUP;
      pc_q    <= `IFU_PC_INIT;
      beat_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      pc_q    <= pc_d;
      if (state_q == ifu_pkg::ST_ADDR)
      begin
        beat_q <= '0;
      end
      else if (beat_we)
      begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state_q == ifu_pkg::ST_LOOKUP) && !lookup_hit_i)
    begin
      refill_way_q <= victim_way_i; // victim is fixed for the whole refill.
    end
  end

  a_arvalid_hold: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_o && !mem_arready_i |=> mem_arvalid_o && $stable(mem_araddr_o));

  a_inst_hold: assert property (@(posedge clk) disable iff (rst)
    inst_valid_o && !inst_ready_i |=>
      inst_valid_o && $stable(inst_o) && $stable(inst_pc_o));

endmodule

`default_nettype wire

// ==== design/way_select.sv ====
`default_nettype none
`include "ifu_macros.svh"

module way_select (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic [`IFU_WAYS-1:0]      way_hit_i,
  input  wire logic [`IFU_ADDR_W-1:0]    way_data_i [`IFU_WAYS],
  input  wire logic [`IFU_SET_BITS-1:0]  set_index_i,
  input  wire logic                      refill_done_i,
  output logic                           lookup_hit_o,
  output logic [`IFU_ADDR_W-1:0]         lookup_inst_o,
  output logic [`IFU_WAY_BITS-1:0]       victim_way_o
);

  localparam logic [`IFU_WAY_BITS-1:0] LAST_WAY = `IFU_WAY_BITS'(`IFU_WAYS - 1);

  logic [`IFU_WAY_BITS-1:0] victim_q [`IFU_SETS];

  assign lookup_hit_o = |way_hit_i;

  always_comb
  begin
    lookup_inst_o = '0;
    for (int w = 0; w < `IFU_WAYS; w++)
    begin
      if (way_hit_i[w])
      begin
        lookup_inst_o = way_data_i[w];
      end
    end
  end

  assign victim_way_o = victim_q[set_index_i];

  // the pointer of a set steps once per completed line.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int s = 0; s < `IFU_SETS; s++)
      begin
        victim_q[s] <= '0;
      end
    end
    else if (refill_done_i)
    begin
      if (victim_q[set_index_i] == LAST_WAY)
      begin
        victim_q[set_index_i] <= '0;
      end
      else
      begin
        victim_q[set_index_i] <= victim_q[set_index_i] + 1'b1;
      end
    end
  end

  // refills happen only on a miss, so a line never lives in two ways.
  a_one_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit_i));

endmodule

`default_nettype wire

// ==== design/icache_way.sv ====
`default_nettype none
`include "ifu_macros.svh"

module icache_way #(
  parameter int WAY_ID = 0
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  icache_if.way                       lookup,
  output logic                        hit_o,
  output logic [`IFU_ADDR_W-1:0]      data_o
);

  localparam logic [`IFU_WAY_BITS-1:0] WAY_SEL = `IFU_WAY_BITS'(WAY_ID);
  localparam logic [`IFU_OFFSET_BITS-1:0] LAST_OFFSET =
    `IFU_OFFSET_BITS'(`IFU_LINE_WORDS - 1);

  logic [`IFU_TAG_W-1:0]  tag_q  [`IFU_SETS];
  logic [`IFU_ADDR_W-1:0] data_q [`IFU_SETS][`IFU_LINE_WORDS];
  logic [`IFU_SETS-1:0]   valid_q;

  logic                   own_we;
  logic                   line_done;

  assign own_we    = lookup.refill_we && (lookup.refill_way == WAY_SEL);
  assign line_done = own_we && (lookup.refill_offset == LAST_OFFSET);

  // a refill always targets the set of the missing pc.
  always_ff @(posedge clk)
  begin
    if (own_we)
    begin
      data_q[lookup.index][lookup.refill_offset] <= lookup.refill_data;
    end
    if (line_done)
    begin
      tag_q[lookup.index] <= lookup.tag;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst || lookup.flush)
    begin
      valid_q <= '0;
    end
    else if (line_done)
    begin
      valid_q[lookup.index] <= 1'b1; // line is usable from the next cycle.
    end
  end

  assign hit_o  = valid_q[lookup.index] && (tag_q[lookup.index] == lookup.tag);
  assign data_o = data_q[lookup.index][lookup.offset];

endmodule

`default_nettype wire

// ==== design/icache_if.sv ====
`default_nettype none
`include "ifu_macros.svh"

interface icache_if;

  logic [`IFU_SET_BITS-1:0]    index;
  logic [`IFU_TAG_W-1:0]       tag;
  logic [`IFU_OFFSET_BITS-1:0] offset;

  logic                        refill_we;
  logic [`IFU_WAY_BITS-1:0]    refill_way;
  logic [`IFU_OFFSET_BITS-1:0] refill_offset;
  logic [`IFU_ADDR_W-1:0]      refill_data;

  logic                        flush; // clears every valid bit in every way.

  modport ctrl (
    output index, tag, offset,
    output refill_we, refill_way, refill_offset, refill_data,
    output flush
  );

  modport way (
    input index, tag, offset,
    input refill_we, refill_way, refill_offset, refill_data,
    input flush
  );

endinterface

`default_nettype wire

// ==== design/ifu_pkg.sv ====
`default_nettype none

package ifu_pkg;

  typedef enum logic [1:0] {
    ST_LOOKUP        = 2'd0, // present the pc or detect a miss.
    ST_ADDR          = 2'd1,
    ST_BEAT          = 2'd2, // refill beats arrive here.
    ST_WAIT_REDIRECT = 2'd3
  } fetch_state_e;

  // only the opcodes fetch cares about, plus the ones used to build programs.
  typedef enum logic [6:0] {
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_BRANCH   = 7'b1100011,
    OP_SYSTEM   = 7'b1110011,
    OP_MISC_MEM = 7'b0001111,
    OP_IMM      = 7'b0010011
  } opcode_e;

  // fence.i with all other fields zero.
  localparam logic [31:0] INST_FENCE_I = 32'h0000_100f;

endpackage

`default_nettype wire

// ==== design/ifu_macros.svh ====
`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

// address and instruction word width.
`define IFU_ADDR_W 32

// each bit width below must match the count next to it.
`define IFU_SETS 4
`define IFU_SET_BITS 2

`define IFU_WAYS 2
`define IFU_WAY_BITS 1

`define IFU_LINE_WORDS 2
`define IFU_OFFSET_BITS 1

// tag is whatever is left above index, word offset and byte offset.
`define IFU_TAG_W (`IFU_ADDR_W - `IFU_SET_BITS - `IFU_OFFSET_BITS - 2)

`define IFU_PC_INIT 32'h8000_0000

`endif
